// File: list.f
+incdir+logic
+incdir+tb
logic/input_event_pkg.sv
logic/cabinet_port_pkg.sv
logic/key_event_router.sv
logic/player_input_channel.sv
logic/cabinet_port_encoder.sv
logic/arcade_input_top.sv
tb/tb_arcade_input.sv

// File: logic/arcade_input_params.svh
// Build-time parameters of the player input subsystem
// Player channel count, joystick word width and the power-up
// orientation that the host drives on rotate

`ifndef ARCADE_INPUT_PARAMS_SVH
`define ARCADE_INPUT_PARAMS_SVH

// Number of player channels, 1 to 4
`define ARCADE_PLAYERS 2

// One joystick word from the host, bits 6 and 7 unused
`define ARCADE_JOY_W 8

// Level of rotate after power-up, 0 is the upright cabinet
`define ARCADE_ROTATE_DEFAULT 1'b0

`endif

// File: logic/arcade_input_top.sv
// Player input subsystem top
// Key router, one input channel per player and the port encoder

`timescale 1ns/1ps
`default_nettype none
`include "arcade_input_params.svh"

module arcade_input_top (
	input  wire logic                                        clk_sys,
	input  wire logic                                        rst_n,
	input  wire logic                                        key_strobe,
	input  wire input_event_pkg::key_event_t                 key_evt,
	input  wire logic [`ARCADE_PLAYERS-1:0][`ARCADE_JOY_W-1:0] joystick,
	input  wire logic                                        rotate,
	output cabinet_port_pkg::port_byte_t                     in0,
	output cabinet_port_pkg::port_byte_t                     in1
);
	import input_event_pkg::*;
	import cabinet_port_pkg::*;

	localparam int NP = `ARCADE_PLAYERS;

	pad_event_t   [NP-1:0] pad_evt;     // Router to channels
	pad_state_t   [NP-1:0] pads;        // Channels to encoder
	sys_buttons_t          sys_btn;

	key_event_router u_key_event_router (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.key_strobe (key_strobe),
		.key_evt    (key_evt),
		.pad_evt    (pad_evt),
		.sys_btn    (sys_btn)
	);

	for (genvar p = 0; p < NP; p++) begin : g_player
		player_input_channel u_player_input_channel (
			.clk_sys  (clk_sys),
			.rst_n    (rst_n),
			.pad_evt  (pad_evt[p]),
			.joystick (joystick[p]),
			.rotate   (rotate),
			.pad      (pads[p])
		);
	end

	cabinet_port_encoder u_cabinet_port_encoder (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.pads    (pads),
		.sys_btn (sys_btn),
		.in0     (in0),
		.in1     (in1)
	);

endmodule

`default_nettype wire

// File: logic/cabinet_port_encoder.sv
// Cabinet port encoder
// Shared control set built from all player pads, packed with the
// system buttons into the active-low in0 and in1 bytes

`timescale 1ns/1ps
`default_nettype none
`include "arcade_input_params.svh"

module cabinet_port_encoder (
	input  wire logic                                          clk_sys,
	input  wire logic                                          rst_n,
	input  wire cabinet_port_pkg::pad_state_t [`ARCADE_PLAYERS-1:0] pads,
	input  wire cabinet_port_pkg::sys_buttons_t                sys_btn,
	output cabinet_port_pkg::port_byte_t                       in0,
	output cabinet_port_pkg::port_byte_t                       in1
);
	import cabinet_port_pkg::*;

	localparam int NP = `ARCADE_PLAYERS;

	pad_state_t any_pad;                // All players on one control set

	always_comb begin
		any_pad = '0;
		for (int p = 0; p < NP; p++) begin
			any_pad = any_pad | pads[p];
		end
	end

	// ========================================================================
	// Port packing
	// ========================================================================
	// in0 = ~{0, 0, coin, 0, down, right, left, up}
	// in1 = ~{0, start2 | fire1, start1, 0, 0, 0, 0, 0}
	// fire2 and fire3 have no port bit here
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			in0 <= 8'hFF;               // All inputs released
			in1 <= 8'hFF;
		end else begin
			in0 <= ~{2'b00, sys_btn.coin, 1'b0,
				any_pad.down, any_pad.right, any_pad.left, any_pad.up};
			in1 <= ~{1'b0, sys_btn.start2 | any_pad.fire1, sys_btn.start1, 5'b00000};
		end
	end

endmodule

`default_nettype wire

// File: logic/cabinet_port_pkg.sv
// Cabinet side types
// Merged pad state of one player, system buttons and the
// active-low input port byte read by the game CPU

`default_nettype none

package cabinet_port_pkg;

	// One player's controls after key, joystick and rotation merge
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;                    // Not wired to a port on this cabinet
		logic fire3;                    // Not wired to a port on this cabinet
	} pad_state_t;

	// Buttons shared by the whole cabinet
	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
	} sys_buttons_t;

	typedef logic [7:0] port_byte_t;    // Active low, 0xFF when idle

endpackage

`default_nettype wire

// File: logic/input_event_pkg.sv
// Host side event types
// Key code, strobed key event, pad button index and the routed
// per-player pad event

`default_nettype none

package input_event_pkg;

	// ========================================================================
	// Key events from the host
	// ========================================================================
	typedef logic [7:0] key_code_t;

	typedef struct packed {
		logic      pressed;             // 1 on make, 0 on break
		key_code_t code;
	} key_event_t;

	// ========================================================================
	// Pad events after routing
	// ========================================================================
	typedef logic [2:0] btn_idx_t;

	localparam btn_idx_t BTN_UP    = 3'd0;
	localparam btn_idx_t BTN_DOWN  = 3'd1;
	localparam btn_idx_t BTN_LEFT  = 3'd2;
	localparam btn_idx_t BTN_RIGHT = 3'd3;
	localparam btn_idx_t BTN_FIRE1 = 3'd4;
	localparam btn_idx_t BTN_FIRE2 = 3'd5;
	localparam btn_idx_t BTN_FIRE3 = 3'd6;

	typedef struct packed {
		logic     valid;                // High for one cycle per routed key
		logic     pressed;
		btn_idx_t idx;
	} pad_event_t;

endpackage

`default_nettype wire

// File: logic/key_event_router.sv
// Key event router
// Maps strobed host key codes onto per-player pad events and
// keeps the coin and start button latches

`timescale 1ns/1ps
`default_nettype none
`include "arcade_input_params.svh"

module key_event_router (
	input  wire logic                                         clk_sys,
	input  wire logic                                         rst_n,
	input  wire logic                                         key_strobe,
	input  wire input_event_pkg::key_event_t                  key_evt,
	output input_event_pkg::pad_event_t [`ARCADE_PLAYERS-1:0] pad_evt,
	output cabinet_port_pkg::sys_buttons_t                    sys_btn
);
	import input_event_pkg::*;
	import cabinet_port_pkg::*;

	localparam int NP = `ARCADE_PLAYERS;

	// One entry of the key map
	typedef struct packed {
		logic     hit;
		logic     player;               // Map covers players 0 and 1
		btn_idx_t idx;
	} key_map_t;

	key_map_t     pad_map;
	sys_buttons_t sys_hit;              // One-hot select of a system button

	// ========================================================================
	// Key map
	// ========================================================================
	always_comb begin
		pad_map = '0;
		sys_hit = '0;
		case (key_evt.code)
			8'h75: pad_map = '{1'b1, 1'b0, BTN_UP};      // Cursor keys
			8'h72: pad_map = '{1'b1, 1'b0, BTN_DOWN};
			8'h6B: pad_map = '{1'b1, 1'b0, BTN_LEFT};
			8'h74: pad_map = '{1'b1, 1'b0, BTN_RIGHT};
			8'h29: pad_map = '{1'b1, 1'b0, BTN_FIRE1};   // Space bar
			8'h11: pad_map = '{1'b1, 1'b0, BTN_FIRE2};   // Alt
			8'h14: pad_map = '{1'b1, 1'b0, BTN_FIRE3};   // Ctrl
			8'h2D: pad_map = '{1'b1, 1'b1, BTN_UP};      // R F D G cluster
			8'h2B: pad_map = '{1'b1, 1'b1, BTN_DOWN};
			8'h23: pad_map = '{1'b1, 1'b1, BTN_LEFT};
			8'h34: pad_map = '{1'b1, 1'b1, BTN_RIGHT};
			8'h1C: pad_map = '{1'b1, 1'b1, BTN_FIRE1};   // A S Z
			8'h1B: pad_map = '{1'b1, 1'b1, BTN_FIRE2};
			8'h1A: pad_map = '{1'b1, 1'b1, BTN_FIRE3};
			8'h76: sys_hit.coin   = 1'b1;                // Escape
			8'h05: sys_hit.start1 = 1'b1;                // F1
			8'h06: sys_hit.start2 = 1'b1;                // F2
			default: ;
		endcase
	end

	// ========================================================================
	// Registered outputs
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			pad_evt <= '0;
			sys_btn <= '0;
		end else begin
			// Player 1 codes match no channel when only one player is built
			for (int p = 0; p < NP; p++) begin
				pad_evt[p].valid   <= key_strobe && pad_map.hit && (int'(pad_map.player) == p);
				pad_evt[p].pressed <= key_evt.pressed;
				pad_evt[p].idx     <= pad_map.idx;
			end
			if (key_strobe)
				sys_btn <= (sys_btn & ~sys_hit) | (sys_hit & {3{key_evt.pressed}});
		end
	end

endmodule

`default_nettype wire

// File: logic/player_input_channel.sv
// Player input channel
// Key latch written by routed pad events, merge with the player's
// joystick word and rotation of the four directions

`timescale 1ns/1ps
`default_nettype none
`include "arcade_input_params.svh"

module player_input_channel (
	input  wire logic                        clk_sys,
	input  wire logic                        rst_n,
	input  wire input_event_pkg::pad_event_t pad_evt,
	input  wire logic [`ARCADE_JOY_W-1:0]    joystick,
	input  wire logic                        rotate,
	output cabinet_port_pkg::pad_state_t     pad
);
	import input_event_pkg::*;
	import cabinet_port_pkg::*;

	// Joystick bit positions, bits 6 and 7 carry nothing
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE1 = 4;
	localparam int JOY_FIRE2 = 5;

	pad_state_t key_lat;
	pad_state_t merged;                 // Keys OR joystick, still upright

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			key_lat <= '0;
		end else if (pad_evt.valid) begin
			case (pad_evt.idx)
				BTN_UP:    key_lat.up    <= pad_evt.pressed;
				BTN_DOWN:  key_lat.down  <= pad_evt.pressed;
				BTN_LEFT:  key_lat.left  <= pad_evt.pressed;
				BTN_RIGHT: key_lat.right <= pad_evt.pressed;
				BTN_FIRE1: key_lat.fire1 <= pad_evt.pressed;
				BTN_FIRE2: key_lat.fire2 <= pad_evt.pressed;
				BTN_FIRE3: key_lat.fire3 <= pad_evt.pressed;
				default: ;
			endcase
		end
	end

	always_comb begin
		merged.up    = key_lat.up    | joystick[JOY_UP];
		merged.down  = key_lat.down  | joystick[JOY_DOWN];
		merged.left  = key_lat.left  | joystick[JOY_LEFT];
		merged.right = key_lat.right | joystick[JOY_RIGHT];
		merged.fire1 = key_lat.fire1 | joystick[JOY_FIRE1];
		merged.fire2 = key_lat.fire2 | joystick[JOY_FIRE2];
		merged.fire3 = key_lat.fire3;   // Keyboard only
	end

	// Rotated cabinet turns the stick a quarter turn
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			pad <= '0;
		end else begin
			pad <= merged;
			if (rotate) begin
				pad.up    <= merged.left;
				pad.down  <= merged.right;
				pad.left  <= merged.down;
				pad.right <= merged.up;
			end
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the player input testbench with Verilator, runs it into a log
# and decides pass or fail from the log contents

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=tb_arcade_input

verilator --binary --timing --assert -f list.f --top-module "$TOP" -Mdir "$OBJ" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$OBJ/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed!" "$LOG"; then
	exit 0
fi
echo "Simulation did not report success, see $LOG"
exit 1

// File: tb/arcade_input_model.svh
// Reference model of the player input subsystem
// Key and system latches, joystick words, rotation and the
// active-low port packing, included inside the testbench module

`ifndef ARCADE_INPUT_MODEL_SVH
`define ARCADE_INPUT_MODEL_SVH

// Host codes in slot order where slot is player * 7 + button index
localparam logic [7:0] PAD_CODES [14] = '{
	8'h75, 8'h72, 8'h6B, 8'h74, 8'h29, 8'h11, 8'h14,
	8'h2D, 8'h2B, 8'h23, 8'h34, 8'h1C, 8'h1B, 8'h1A
};
localparam logic [7:0] SYS_CODES [3] = '{8'h76, 8'h05, 8'h06};   // Coin, start1, start2

logic [6:0]               model_keys [`ARCADE_PLAYERS];   // Bit n is button index n
logic [2:0]               model_sys;                      // Bit 0 coin, 1 start1, 2 start2
logic [`ARCADE_JOY_W-1:0] model_joy  [`ARCADE_PLAYERS];
logic                     model_rot;

function automatic void clear_model();
	for (int p = 0; p < `ARCADE_PLAYERS; p++) begin
		model_keys[p] = '0;
		model_joy[p]  = '0;
	end
	model_sys = '0;
	model_rot = `ARCADE_ROTATE_DEFAULT;
endfunction

function automatic int pad_slot(input logic [7:0] code);
	for (int i = 0; i < 14; i++) begin
		if (PAD_CODES[i] == code)
			return i;
	end
	return -1;
endfunction

function automatic int sys_slot(input logic [7:0] code);
	for (int i = 0; i < 3; i++) begin
		if (SYS_CODES[i] == code)
			return i;
	end
	return -1;
endfunction

function automatic bit is_mapped(input logic [7:0] code);
	return (pad_slot(code) >= 0) || (sys_slot(code) >= 0);
endfunction

// Player 1 codes drop out when only one player is built
function automatic void apply_key(input logic [7:0] code, input logic pressed);
	int slot;
	int player;
	slot   = pad_slot(code);
	player = slot / 7;
	if (slot >= 0 && player < `ARCADE_PLAYERS)
		model_keys[player][slot % 7] = pressed;
	slot = sys_slot(code);
	if (slot >= 0)
		model_sys[slot] = pressed;
endfunction

// All players on one control set as {fire1, down, right, left, up}
function automatic logic [4:0] shared_controls();
	logic [4:0] acc;
	logic       up;
	logic       down;
	logic       left;
	logic       right;
	logic       fire1;
	acc = '0;
	for (int p = 0; p < `ARCADE_PLAYERS; p++) begin
		up    = model_keys[p][0] | model_joy[p][3];
		down  = model_keys[p][1] | model_joy[p][2];
		left  = model_keys[p][2] | model_joy[p][1];
		right = model_keys[p][3] | model_joy[p][0];
		fire1 = model_keys[p][4] | model_joy[p][4];
		if (model_rot)
			acc = acc | {fire1, right, up, down, left};   // Quarter turn
		else
			acc = acc | {fire1, down, right, left, up};
	end
	return acc;
endfunction

function automatic logic [7:0] expect_in0();
	logic [4:0] ctl;
	ctl = shared_controls();
	return ~{2'b00, model_sys[0], 1'b0, ctl[3:0]};
endfunction

function automatic logic [7:0] expect_in1();
	logic [4:0] ctl;
	ctl = shared_controls();
	return ~{1'b0, model_sys[2] | ctl[4], model_sys[1], 5'b00000};
endfunction

`endif

// File: tb/tb_arcade_input.sv
// Testbench of the player input subsystem
// Clock and reset, random key, joystick and rotate stimulus,
// port checks against the included model and a watchdog

`timescale 1ns/1ps
`default_nettype none
`include "arcade_input_params.svh"

module tb_arcade_input;
	import input_event_pkg::*;
	import cabinet_port_pkg::*;

	localparam int NP          = `ARCADE_PLAYERS;
	localparam int CLK_PERIOD  = 40;
	localparam int STEPS_KEYS  = 60;
	localparam int STEPS_JOY   = 40;
	localparam int STEPS_ROT   = 40;
	localparam int STEPS_CLEAR = 2;
	localparam int STEPS_SYS   = 40;
	localparam int TOTAL_STEPS = 1 + STEPS_KEYS + STEPS_JOY + STEPS_ROT + STEPS_CLEAR
		+ STEPS_SYS;

	logic                               clk_sys;
	logic                               rst_n;
	logic                               key_strobe;
	key_event_t                         key_evt;
	logic [NP-1:0][`ARCADE_JOY_W-1:0]   joystick;
	logic                               rotate;
	port_byte_t                         in0;
	port_byte_t                         in1;

	int seed;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;

	`include "arcade_input_model.svh"

	arcade_input_top u_arcade_input_top (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.key_strobe (key_strobe),
		.key_evt    (key_evt),
		.joystick   (joystick),
		.rotate     (rotate),
		.in0        (in0),
		.in1        (in1)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ========================================================================
	// Stimulus helpers
	// ========================================================================
	function automatic int random_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7FFF_FFFF) % n;
	endfunction

	function automatic logic [7:0] random_unmapped_code();
		int         r;
		logic [7:0] code;
		r    = random_below(256);
		code = r[7:0];
		while (is_mapped(code)) begin
			r    = random_below(256);
			code = r[7:0];
		end
		return code;
	endfunction

	task automatic randomize_joysticks();
		int r;
		for (int p = 0; p < NP; p++) begin
			r = random_below(256);
			model_joy[p] = r[`ARCADE_JOY_W-1:0];
		end
	endtask

	task automatic check_ports();
		port_byte_t exp0;
		port_byte_t exp1;
		exp0 = expect_in0();
		exp1 = expect_in1();
		checks += 2;
		assert (in0 === exp0) else begin
			$display("[ERROR] in0 expected 0x%h got 0x%h", exp0, in0);
			errors++;
		end
		assert (in1 === exp1) else begin
			$display("[ERROR] in1 expected 0x%h got 0x%h", exp1, in1);
			errors++;
		end
	endtask

	// One strobe plus the current joystick and rotate levels, then a settled check
	task automatic run_step(input logic strobe, input logic [7:0] code, input logic pressed);
		logic [NP-1:0][`ARCADE_JOY_W-1:0] joy_word;
		for (int p = 0; p < NP; p++)
			joy_word[p] = model_joy[p];
		@(posedge clk_sys);
		key_strobe <= strobe;
		key_evt    <= '{pressed, code};
		joystick   <= joy_word;
		rotate     <= model_rot;
		@(posedge clk_sys);
		key_strobe <= 1'b0;
		if (strobe)
			apply_key(code, pressed);
		repeat (6) @(posedge clk_sys);    // Past every port latency
		@(negedge clk_sys);
		check_ports();
	endtask

	task automatic report_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("%-20s ok", name);
		end else begin
			tests_failed++;
			$display("%-20s FAILED with %0d errors", name, errors - err_start);
		end
	endtask

	// ========================================================================
	// Tests
	// ========================================================================
	initial begin
		int err_start;
		clk_sys    = 1'b0;
		rst_n      = 1'b0;
		key_strobe = 1'b0;
		key_evt    = '0;
		joystick   = '0;
		rotate     = `ARCADE_ROTATE_DEFAULT;
		seed       = 35;
		errors     = 0;
		checks     = 0;
		tests_run  = 0;
		tests_failed = 0;
		clear_model();
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;

		err_start = errors;
		@(negedge clk_sys);
		check_ports();                    // Port registers straight out of reset
		run_step(1'b0, 8'h00, 1'b0);      // Idle ports
		report_test("reset", err_start);

		err_start = errors;
		for (int i = 0; i < STEPS_KEYS; i++)
			run_step(1'b1, PAD_CODES[random_below(14)], random_below(2) == 1);
		report_test("key strobes", err_start);

		err_start = errors;
		for (int i = 0; i < STEPS_JOY; i++) begin
			randomize_joysticks();
			run_step(1'b1, PAD_CODES[random_below(14)], random_below(2) == 1);
		end
		report_test("joystick merge", err_start);

		err_start = errors;
		for (int i = 0; i < STEPS_ROT; i++) begin
			randomize_joysticks();
			model_rot = (random_below(2) == 1);
			run_step(1'b1, PAD_CODES[random_below(14)], random_below(2) == 1);
		end
		report_test("rotation", err_start);

		// Fire1 released on keys and sticks so start2 alone drives in1 bit 6
		err_start = errors;
		for (int p = 0; p < NP; p++)
			model_joy[p] = '0;
		run_step(1'b1, PAD_CODES[int'(BTN_FIRE1)], 1'b0);
		run_step(1'b1, PAD_CODES[7 + int'(BTN_FIRE1)], 1'b0);

		// System buttons interleaved with codes outside the map
		for (int i = 0; i < STEPS_SYS; i++) begin
			if (random_below(2) == 1)
				run_step(1'b1, SYS_CODES[random_below(3)], random_below(2) == 1);
			else
				run_step(1'b1, random_unmapped_code(), random_below(2) == 1);
		end
		report_test("system and unmapped", err_start);

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Watchdog allows ten clock periods per step
	initial begin
		#(TOTAL_STEPS * 10 * CLK_PERIOD);
		$display("Timeout, the tests did not finish in the expected time");
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire
